/* mem_sys.f */
common/mem_sys_pkg.sv
cache/cache_array.sv
cache/cache_fill_fsm.sv
cache/d_cache.sv
hdl/main_memory.sv
hdl/miss_arbiter.sv
hdl/mem_sys_top.sv
tb/mem_sys_checker.sv
tb/tb_mem_sys.sv

/* Makefile */
# Verilator flow for the cache and memory system

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_mem_sys -f mem_sys.f

sim:
	verilator --binary --timing --assert --top-module tb_mem_sys -f mem_sys.f -o tb_mem_sys
	./obj_dir/tb_mem_sys | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_mem_sys.sv */
module tb_mem_sys;

	localparam int FETCH_WORDS = 32; // four sequential blocks
	localparam int NUM_LOADS = 40;
	localparam int NUM_STORE_ADDRS = 12; // store twice, load, evict, reload
	localparam int CONFLICT_ROUNDS = 8;
	localparam int SIM_ROUNDS = 6; // fetch miss with load, store miss, store hit
	localparam int TOTAL_ACCESSES = FETCH_WORDS + NUM_LOADS + 5 * NUM_STORE_ADDRS
		+ 2 * CONFLICT_ROUNDS + 3 * SIM_ROUNDS; // upper bound
	localparam int WATCHDOG_CYCLES = TOTAL_ACCESSES * 40;

	logic clk = 1'b0;
	logic rst_n;
	logic [2:0] test_id; // names the running test in error lines
	logic [mem_sys_pkg::WORD_W-1:0] pc_addr, data_addr, data_in;
	logic mem_read, mem_write;
	logic [mem_sys_pkg::WORD_W-1:0] i_data, d_data;
	logic if_stall, mem_stall;
	int error_count, check_count;
	logic [31:0] rng_state = 32'd48;

	logic [15:0] fetch_q [$]; // pending fetch addresses
	logic [15:0] op_addr_q [$]; // pending data accesses
	logic [15:0] op_data_q [$];
	logic op_store_q [$];
	logic [15:0] store_addrs [$];

	always #2 clk = ~clk;

	mem_sys_top mem_sys_top_i (
		.clk(clk), .rst_n(rst_n), .pc_addr(pc_addr), .data_addr(data_addr),
		.data_in(data_in), .mem_read(mem_read), .mem_write(mem_write),
		.i_data(i_data), .d_data(d_data), .if_stall(if_stall), .mem_stall(mem_stall)
	);

	mem_sys_checker checker_i (
		.clk(clk), .rst_n(rst_n), .test_id(test_id), .pc_addr(pc_addr),
		.data_addr(data_addr), .data_in(data_in), .mem_read(mem_read),
		.mem_write(mem_write), .i_data(i_data), .d_data(d_data), .if_stall(if_stall),
		.mem_stall(mem_stall), .error_count(error_count), .check_count(check_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_random(output logic [15:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state[15:0];
	endtask

	task automatic queue_op(input logic [15:0] addr, input logic [15:0] data,
		input logic is_store);
		op_addr_q.push_back(addr);
		op_data_q.push_back(data);
		op_store_q.push_back(is_store);
	endtask

	// each side moves on only when its stall is low
	task automatic run_until_idle();
		logic done;
		logic is_store;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			done = (fetch_q.size() == 0) && (op_addr_q.size() == 0) && !if_stall && !mem_stall;
			if (!if_stall && fetch_q.size() > 0)
				pc_addr <= fetch_q.pop_front();
			if (!mem_stall && op_addr_q.size() > 0)
			begin
				is_store = op_store_q.pop_front();
				data_addr <= op_addr_q.pop_front();
				data_in <= op_data_q.pop_front();
				mem_write <= is_store;
				mem_read <= !is_store;
			end
			else if (!mem_stall)
			begin
				mem_read <= 1'b0; // data side idle
				mem_write <= 1'b0;
			end
		end
	endtask

	initial
	begin
		logic [15:0] rnd;
		logic [15:0] base;
		logic [15:0] other;
		logic [15:0] prev;
		rst_n <= 1'b0;
		test_id <= 3'd0;
		pc_addr <= '0;
		data_addr <= '0;
		data_in <= '0;
		mem_read <= 1'b0;
		mem_write <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk); // quiet data side right after reset

		test_id <= 3'd1; // fetch region keeps bit 12 clear
		draw_random(rnd);
		base = rnd & 16'hEF00;
		for (int k = 0; k < FETCH_WORDS; k++)
			fetch_q.push_back(base + 16'(2 * k));
		run_until_idle();

		test_id <= 3'd2; // data region has bit 12 set
		for (int k = 0; k < NUM_LOADS; k++)
		begin
			draw_random(rnd);
			queue_op(16'h1000 | (rnd & 16'h03FF), 16'h0000, 1'b0);
		end
		run_until_idle();

		test_id <= 3'd3;
		for (int k = 0; k < NUM_STORE_ADDRS; k++)
		begin
			draw_random(rnd);
			store_addrs.push_back(rnd | 16'h1000);
			draw_random(rnd);
			queue_op(store_addrs[k], rnd, 1'b1); // miss, allocate
			draw_random(rnd);
			queue_op(store_addrs[k], rnd, 1'b1); // hit
		end
		foreach (store_addrs[k])
			queue_op(store_addrs[k], 16'h0000, 1'b0);
		foreach (store_addrs[k])
			queue_op(store_addrs[k] ^ 16'h0200, 16'h0000, 1'b0); // same set, evicts
		foreach (store_addrs[k])
			queue_op(store_addrs[k], 16'h0000, 1'b0); // back from memory
		run_until_idle();

		test_id <= 3'd4;
		draw_random(rnd);
		base = 16'h1000 | (rnd & 16'h01F0);
		other = base ^ 16'h0400; // other tag, same index
		for (int k = 0; k < CONFLICT_ROUNDS; k++)
		begin
			draw_random(rnd);
			queue_op(base | (rnd & 16'h000E), 16'h0000, 1'b0);
			queue_op(other | (rnd & 16'h000E), 16'h0000, 1'b0);
		end
		run_until_idle();

		test_id <= 3'd5;
		prev = 16'h1000;
		for (int k = 0; k < SIM_ROUNDS; k++)
		begin
			draw_random(rnd);
			fetch_q.push_back(rnd & 16'hEFFE); // fresh fetch block
			draw_random(rnd);
			if (k % 3 == 2)
			begin
				prev = (prev & 16'hFFF0) | (rnd & 16'h000E);
				queue_op(prev, 16'h0000, 1'b0); // hit, lets the fetch fill start
			end
			else
				prev = rnd | 16'h1000;
			draw_random(rnd);
			queue_op(prev, rnd, k % 3 != 0); // store lands during or after a fill
			run_until_idle();
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		$display("closing: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0 && check_count > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, a stall never cleared", WATCHDOG_CYCLES);
		$display("closing: %0d checks, %0d errors", check_count, error_count);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* tb/mem_sys_checker.sv */
module mem_sys_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic [2:0] test_id, // selects the name in error lines
	input  logic [mem_sys_pkg::WORD_W-1:0] pc_addr,
	input  logic [mem_sys_pkg::WORD_W-1:0] data_addr,
	input  logic [mem_sys_pkg::WORD_W-1:0] data_in,
	input  logic mem_read,
	input  logic mem_write,
	input  logic [mem_sys_pkg::WORD_W-1:0] i_data,
	input  logic [mem_sys_pkg::WORD_W-1:0] d_data,
	input  logic if_stall,
	input  logic mem_stall,
	output int error_count,
	output int check_count
);

	localparam int AW = mem_sys_pkg::MEM_AW;

	logic [mem_sys_pkg::WORD_W-1:0] ref_mem [mem_sys_pkg::MEM_WORDS]; // expected image
	logic after_reset; // first edge out of reset
	logic data_seen; // first data access already checked

	function automatic string test_label(input logic [2:0] id);
		case (id)
			3'd1: return "fetch";
			3'd2: return "loads";
			3'd3: return "stores";
			3'd4: return "conflict";
			3'd5: return "simultaneous";
			default: return "reset";
		endcase
	endfunction

	// byte address to word slot, modulo the memory size
	function automatic logic [AW-1:0] word_index(input logic [15:0] byte_addr);
		return AW'((byte_addr >> 1) % mem_sys_pkg::MEM_WORDS);
	endfunction

	function automatic logic [15:0] expected_word(input logic [15:0] byte_addr);
		return ref_mem[word_index(byte_addr)];
	endfunction

	task automatic compare_word(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERROR %s: %s expected %h actual %h", test_label(test_id), what,
				expected, actual);
		end
	endtask

	task automatic compare_bit(input string what, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERROR %s: %s expected %b actual %b", test_label(test_id), what,
				expected, actual);
		end
	endtask

	// sampled at the edge, before any input or register update lands
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			error_count = 0;
			check_count = 0;
			after_reset = 1'b1;
			data_seen = 1'b0;
			for (int i = 0; i < mem_sys_pkg::MEM_WORDS; i++)
			begin
				ref_mem[AW'(i)] = 16'(i) ^ 16'hA5C3; // word address xor key
			end
		end
		else
		begin
			if (after_reset)
			begin
				after_reset = 1'b0;
				compare_bit("if_stall on the first fetch", 1'b1, if_stall); // cold cache
			end
			if (!mem_read && !mem_write)
				compare_bit("mem_stall with no data access", 1'b0, mem_stall);
			else if (!data_seen)
			begin
				data_seen = 1'b1;
				compare_bit("mem_stall on the first data access", 1'b1, mem_stall);
			end
			if (!if_stall)
				compare_word($sformatf("fetch %h", pc_addr), expected_word(pc_addr), i_data);
			if (mem_read && !mem_stall)
				compare_word($sformatf("load %h", data_addr), expected_word(data_addr), d_data);
			if (mem_write && !mem_stall)
				ref_mem[word_index(data_addr)] = data_in; // store accepted at this edge
		end
	end

endmodule

/* hdl/mem_sys_top.sv */
module mem_sys_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [mem_sys_pkg::WORD_W-1:0] pc_addr, // fetch address
	input  logic [mem_sys_pkg::WORD_W-1:0] data_addr, // load/store address
	input  logic [mem_sys_pkg::WORD_W-1:0] data_in, // store data
	input  logic mem_read,
	input  logic mem_write,
	output logic [mem_sys_pkg::WORD_W-1:0] i_data,
	output logic [mem_sys_pkg::WORD_W-1:0] d_data,
	output logic if_stall, // holds the fetch stage
	output logic mem_stall // holds the whole pipe
);

	logic i_hit, i_miss, d_miss, store_wait;
	logic fill_start, fill_busy, rd_en;
	logic [mem_sys_pkg::WORD_W-1:0] fill_base, rd_addr;
	logic fill_we_raw, fill_tag_we_raw;
	logic [mem_sys_pkg::OFFSET_W-1:0] fill_offset;
	logic i_fill_we, i_fill_tag_we, d_fill_we, d_fill_tag_we;
	logic mem_en, mem_wr, mem_rvalid;
	logic [mem_sys_pkg::WORD_W-1:0] mem_addr, mem_wdata, mem_rdata;

	assign i_miss = !i_hit; // fetch is always requested
	assign if_stall = i_miss;
	assign mem_stall = d_miss || store_wait;

	// instruction cache, read only from the pipe side
	cache_array i_cache_i (
		.clk(clk), .rst_n(rst_n), .addr(pc_addr), .rdata(i_data), .hit(i_hit),
		.we(i_fill_we), .woffset(fill_offset), .wdata(mem_rdata), .tag_we(i_fill_tag_we)
	);

	d_cache d_cache_i (
		.clk(clk), .rst_n(rst_n), .addr(data_addr), .wdata_cpu(data_in),
		.mem_read(mem_read), .mem_write(mem_write),
		.fill_we(d_fill_we), .fill_offset(fill_offset), .fill_data(mem_rdata),
		.fill_tag_we(d_fill_tag_we), .rdata(d_data), .miss(d_miss)
	);

	// one fill engine shared by both caches
	cache_fill_fsm fill_fsm_i (
		.clk(clk), .rst_n(rst_n), .fill_start(fill_start), .fill_base(fill_base),
		.fill_busy(fill_busy), .rd_en(rd_en), .rd_addr(rd_addr), .rvalid(mem_rvalid),
		.fill_we(fill_we_raw), .fill_offset(fill_offset), .fill_tag_we(fill_tag_we_raw)
	);

	miss_arbiter arbiter_i (
		.clk(clk), .rst_n(rst_n), .pc_addr(pc_addr), .data_addr(data_addr),
		.data_in(data_in), .mem_write(mem_write), .i_miss(i_miss), .d_miss(d_miss),
		.fill_busy(fill_busy), .rd_en(rd_en), .rd_addr(rd_addr),
		.fill_we_raw(fill_we_raw), .fill_tag_we_raw(fill_tag_we_raw),
		.fill_start(fill_start), .fill_base(fill_base),
		.i_fill_we(i_fill_we), .i_fill_tag_we(i_fill_tag_we),
		.d_fill_we(d_fill_we), .d_fill_tag_we(d_fill_tag_we), .store_wait(store_wait),
		.mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	main_memory memory_i (
		.clk(clk), .rst_n(rst_n), .en(mem_en), .wr(mem_wr), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata), .rvalid(mem_rvalid)
	);

endmodule

/* hdl/miss_arbiter.sv */
module miss_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  logic [mem_sys_pkg::WORD_W-1:0] pc_addr,
	input  logic [mem_sys_pkg::WORD_W-1:0] data_addr,
	input  logic [mem_sys_pkg::WORD_W-1:0] data_in, // store data
	input  logic mem_write,
	input  logic i_miss,
	input  logic d_miss,
	input  logic fill_busy,
	input  logic rd_en, // fill engine read request
	input  logic [mem_sys_pkg::WORD_W-1:0] rd_addr,
	input  logic fill_we_raw,
	input  logic fill_tag_we_raw, // doubles as fill done
	output logic fill_start,
	output logic [mem_sys_pkg::WORD_W-1:0] fill_base,
	output logic i_fill_we,
	output logic i_fill_tag_we,
	output logic d_fill_we,
	output logic d_fill_tag_we,
	output logic store_wait, // store held off by a fill
	output logic mem_en,
	output logic mem_wr,
	output logic [mem_sys_pkg::WORD_W-1:0] mem_addr,
	output logic [mem_sys_pkg::WORD_W-1:0] mem_wdata
);

	mem_sys_pkg::arb_state_t state, next_state;
	logic fill_active; // memory port owned by the fill engine
	logic next_fill;
	logic store_go; // store hit writes memory this cycle
	logic [mem_sys_pkg::WORD_W-1:0] miss_addr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= mem_sys_pkg::ARB_IDLE;
		else
			state <= next_state;
	end

	// a data miss goes before an instruction miss
	always_comb
	begin
		next_state = state;
		case (state)
			mem_sys_pkg::ARB_IDLE:
				if (!fill_busy && d_miss)
					next_state = mem_sys_pkg::ARB_D_FILL;
				else if (!fill_busy && i_miss)
					next_state = mem_sys_pkg::ARB_I_FILL;
			mem_sys_pkg::ARB_I_FILL:
				if (fill_tag_we_raw)
					next_state = d_miss ? mem_sys_pkg::ARB_D_FILL : mem_sys_pkg::ARB_IDLE;
			mem_sys_pkg::ARB_D_FILL:
				if (fill_tag_we_raw && !i_miss)
					next_state = mem_sys_pkg::ARB_IDLE;
				else if (fill_tag_we_raw)
					next_state = mem_write ? mem_sys_pkg::ARB_STORE_WAIT : mem_sys_pkg::ARB_I_FILL;
			default: // store slot lasts one cycle
				next_state = i_miss ? mem_sys_pkg::ARB_I_FILL : mem_sys_pkg::ARB_IDLE;
		endcase
	end

	// fill launches on entry with the block base of the missing address
	assign next_fill = (next_state == mem_sys_pkg::ARB_I_FILL)
		|| (next_state == mem_sys_pkg::ARB_D_FILL);
	assign fill_start = next_fill && (next_state != state);
	assign miss_addr = (next_state == mem_sys_pkg::ARB_D_FILL) ? data_addr : pc_addr;
	assign fill_base = {miss_addr[mem_sys_pkg::WORD_W-1:mem_sys_pkg::INDEX_LSB],
		{mem_sys_pkg::INDEX_LSB{1'b0}}};

	// steer fill writes to the cache in service
	assign i_fill_we = (state == mem_sys_pkg::ARB_I_FILL) && fill_we_raw;
	assign i_fill_tag_we = (state == mem_sys_pkg::ARB_I_FILL) && fill_tag_we_raw;
	assign d_fill_we = (state == mem_sys_pkg::ARB_D_FILL) && fill_we_raw;
	assign d_fill_tag_we = (state == mem_sys_pkg::ARB_D_FILL) && fill_tag_we_raw;

	// write-through store goes out only when the port is free
	assign fill_active = (state == mem_sys_pkg::ARB_I_FILL) || (state == mem_sys_pkg::ARB_D_FILL);
	assign store_go = mem_write && !d_miss && !fill_active;
	assign store_wait = mem_write && !d_miss && fill_active;

	// memory port mux
	assign mem_en = fill_active ? rd_en : store_go;
	assign mem_wr = store_go;
	assign mem_addr = fill_active ? rd_addr : data_addr;
	assign mem_wdata = data_in;

	// fill reads only issue in the fill states where the store path is closed
	a_read_write_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd_en |-> fill_active
	);

	// a new fill starts only on an idle engine or its final return
	a_start_when_free: assert property (
		@(posedge clk) disable iff (!rst_n)
		fill_start |-> !fill_busy || fill_tag_we_raw
	);

endmodule

/* hdl/main_memory.sv */
module main_memory (
	input  logic clk,
	input  logic rst_n,
	input  logic en, // request strobe
	input  logic wr, // 1 write, 0 read
	input  logic [mem_sys_pkg::WORD_W-1:0] addr, // byte address
	input  logic [mem_sys_pkg::WORD_W-1:0] wdata,
	output logic [mem_sys_pkg::WORD_W-1:0] rdata,
	output logic rvalid // read data 4 cycles after request
);

	localparam int LAT = mem_sys_pkg::MEM_LATENCY;

	logic [mem_sys_pkg::WORD_W-1:0] mem_words [mem_sys_pkg::MEM_WORDS];
	logic [mem_sys_pkg::MEM_AW-1:0] waddr; // word address, wraps at 4096
	logic rd_req;
	logic [LAT-1:0] valid_sr; // read in flight per stage
	logic [mem_sys_pkg::MEM_AW-1:0] addr_sr [LAT];

	assign waddr = addr[mem_sys_pkg::WADDR_LSB +: mem_sys_pkg::MEM_AW]; // bits 12:1
	assign rd_req = en && !wr;

	// known power-up content
	initial
	begin
		for (int i = 0; i < mem_sys_pkg::MEM_WORDS; i++)
		begin
			mem_words[i] = mem_sys_pkg::mem_init_word(i[mem_sys_pkg::MEM_AW-1:0]);
		end
	end

	// writes land at the enabling edge
	always @(posedge clk)
	begin
		if (en && wr)
		begin
			mem_words[waddr] <= wdata;
		end
	end

	// valid pipe, up to LAT reads in flight
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_sr <= '0;
		end
		else
		begin
			valid_sr <= {valid_sr[LAT-2:0], rd_req};
		end
	end

	// address pipe follows the valid bits
	always_ff @(posedge clk)
	begin
		addr_sr[0] <= waddr;
		for (int i = 1; i < LAT; i++)
		begin
			addr_sr[i] <= addr_sr[i-1];
		end
	end

	// array read at the last stage
	assign rvalid = valid_sr[LAT-1];
	assign rdata = mem_words[addr_sr[LAT-1]]; // no store runs while a fill is in flight

endmodule

/* cache/d_cache.sv */
module d_cache (
	input  logic clk,
	input  logic rst_n,
	input  logic [mem_sys_pkg::WORD_W-1:0] addr, // pipeline data address
	input  logic [mem_sys_pkg::WORD_W-1:0] wdata_cpu, // store data
	input  logic mem_read,
	input  logic mem_write,
	input  logic fill_we, // already gated by the arbiter
	input  logic [mem_sys_pkg::OFFSET_W-1:0] fill_offset,
	input  logic [mem_sys_pkg::WORD_W-1:0] fill_data, // memory rdata
	input  logic fill_tag_we,
	output logic [mem_sys_pkg::WORD_W-1:0] rdata, // load word
	output logic miss
);

	logic hit;
	logic store_we; // store that hits the line
	logic we;
	logic [mem_sys_pkg::OFFSET_W-1:0] woffset;
	logic [mem_sys_pkg::WORD_W-1:0] wdata;

	assign miss = (mem_read || mem_write) && !hit; // only while an access is asked
	assign store_we = mem_write && hit; // store miss completes as a hit after the fill

	// merge the two write sources into the single word port
	assign we = store_we || fill_we;
	assign woffset = store_we ? addr[mem_sys_pkg::OFFSET_LSB +: mem_sys_pkg::OFFSET_W]
		: fill_offset;
	assign wdata = store_we ? wdata_cpu : fill_data;

	cache_array array_i (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.rdata(rdata),
		.hit(hit),
		.we(we),
		.woffset(woffset),
		.wdata(wdata),
		.tag_we(fill_tag_we)
	);

	// fills only run for a missing line, so no store can hit during one
	a_no_store_during_fill: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(store_we && fill_we)
	);

endmodule

/* cache/cache_fill_fsm.sv */
module cache_fill_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic fill_start, // one cycle pulse from the arbiter
	input  logic [mem_sys_pkg::WORD_W-1:0] fill_base, // block aligned byte address
	output logic fill_busy,
	output logic rd_en, // memory read request
	output logic [mem_sys_pkg::WORD_W-1:0] rd_addr,
	input  logic rvalid, // memory return strobe
	output logic fill_we, // one pulse per returned word
	output logic [mem_sys_pkg::OFFSET_W-1:0] fill_offset,
	output logic fill_tag_we // with the last word
);

	logic [mem_sys_pkg::WORD_W-1:0] base; // latched block address
	logic issuing; // reads still to issue
	logic [mem_sys_pkg::OFFSET_W-1:0] issue_cnt; // next word to request
	logic [mem_sys_pkg::OFFSET_W-1:0] ret_cnt; // next word to come back
	logic last_issue;
	logic last_ret;

	assign last_issue = (issue_cnt == '1); // 8th request
	assign last_ret = (ret_cnt == '1); // 8th return

	// request side, base plus two bytes per word
	assign rd_en = issuing;
	assign rd_addr = base + {{(mem_sys_pkg::WORD_W - mem_sys_pkg::OFFSET_W - 1){1'b0}},
		issue_cnt, 1'b0};

	// return side, words land in the order they were asked for
	assign fill_we = fill_busy && rvalid;
	assign fill_offset = ret_cnt;
	assign fill_tag_we = fill_we && last_ret; // tag goes in with the last word

	// block address held for the whole fill
	always_ff @(posedge clk)
	begin
		if (fill_start)
		begin
			base <= fill_base;
		end
	end

	// issue counter, reads on the 8 cycles after fill_start
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			issuing <= 1'b0;
			issue_cnt <= '0;
		end
		else if (fill_start)
		begin
			issuing <= 1'b1;
			issue_cnt <= '0;
		end
		else if (issuing)
		begin
			issue_cnt <= issue_cnt + 1'b1; // wraps to 0 after word 7
			if (last_issue)
			begin
				issuing <= 1'b0;
			end
		end
	end

	// return counter, busy drops at the tag write edge
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fill_busy <= 1'b0;
			ret_cnt <= '0;
		end
		else if (fill_start)
		begin
			fill_busy <= 1'b1; // may restart on the last return of the previous fill
			ret_cnt <= '0;
		end
		else if (fill_we)
		begin
			ret_cnt <= ret_cnt + 1'b1;
			if (last_ret)
			begin
				fill_busy <= 1'b0;
			end
		end
	end

	// memory only returns what this engine asked for
	a_rvalid_while_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		rvalid |-> fill_busy
	);

endmodule

/* cache/cache_array.sv */
module cache_array (
	input  logic clk,
	input  logic rst_n,
	input  logic [mem_sys_pkg::WORD_W-1:0] addr, // lookup and write address
	output logic [mem_sys_pkg::WORD_W-1:0] rdata, // word at addr offset
	output logic hit,
	input  logic we, // word write at woffset
	input  logic [mem_sys_pkg::OFFSET_W-1:0] woffset,
	input  logic [mem_sys_pkg::WORD_W-1:0] wdata,
	input  logic tag_we // store tag of addr, mark set valid
);

	// storage
	logic [mem_sys_pkg::WORD_W-1:0] data_mem
		[mem_sys_pkg::NUM_SETS][mem_sys_pkg::WORDS_PER_BLOCK];
	logic [mem_sys_pkg::TAG_W-1:0] tag_mem [mem_sys_pkg::NUM_SETS];
	logic [mem_sys_pkg::NUM_SETS-1:0] valid;

	// address fields
	logic [mem_sys_pkg::INDEX_W-1:0] index;
	logic [mem_sys_pkg::OFFSET_W-1:0] offset;
	logic [mem_sys_pkg::TAG_W-1:0] tag;

	assign index = addr[mem_sys_pkg::INDEX_LSB +: mem_sys_pkg::INDEX_W]; // bits 8:4
	assign offset = addr[mem_sys_pkg::OFFSET_LSB +: mem_sys_pkg::OFFSET_W]; // bits 3:1
	assign tag = addr[mem_sys_pkg::TAG_LSB +: mem_sys_pkg::TAG_W]; // bits 15:9

	// combinational lookup, data shows up with the address
	assign rdata = data_mem[index][offset];
	assign hit = valid[index] && (tag_mem[index] == tag);

	// word write, fill or store hit
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			data_mem[index][woffset] <= wdata; // set always comes from addr
		end
	end

	// tag write arrives with the last fill word
	always_ff @(posedge clk)
	begin
		if (tag_we)
		begin
			tag_mem[index] <= tag;
		end
	end

	// valid bits
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid <= '0; // cold cache
		end
		else if (tag_we)
		begin
			valid[index] <= 1'b1; // block now complete
		end
	end

	// the owner must hold addr stable through a fill
	a_write_index_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		(we || tag_we) |-> !$isunknown(index) && !$isunknown(woffset)
	);

endmodule

/* common/mem_sys_pkg.sv */
package mem_sys_pkg;

	// datapath
	localparam int WORD_W = 16; // data and byte address width

	// cache geometry
	localparam int WORDS_PER_BLOCK = 8;
	localparam int OFFSET_W = 3; // word within block
	localparam int NUM_SETS = 32;
	localparam int INDEX_W = 5; // set select
	localparam int TAG_W = 7;

	// address field positions, bit 0 is the byte lane and is dropped
	localparam int WADDR_LSB = 1;
	localparam int OFFSET_LSB = WADDR_LSB; // bits 3:1
	localparam int INDEX_LSB = OFFSET_LSB + OFFSET_W; // bits 8:4
	localparam int TAG_LSB = INDEX_LSB + INDEX_W; // bits 15:9

	// main memory
	localparam int MEM_WORDS = 4096;
	localparam int MEM_AW = 12; // word address, bits 12:1
	localparam int MEM_LATENCY = 4; // read enable to rvalid

	localparam logic [WORD_W-1:0] INIT_KEY = 16'hA5C3; // power-up pattern

	// miss service state
	typedef enum logic [1:0]
	{
		ARB_IDLE = 2'b00, // nothing in service
		ARB_I_FILL = 2'b01, // refilling instruction cache
		ARB_D_FILL = 2'b10, // refilling data cache
		ARB_STORE_WAIT = 2'b11 // slot for a held store before an i fill
	} arb_state_t;

	// power-up content of one memory word, shared with the reference model
	function automatic logic [WORD_W-1:0] mem_init_word(input logic [MEM_AW-1:0] waddr);
		logic [WORD_W-1:0] wide_addr;
		wide_addr = {{(WORD_W - MEM_AW){1'b0}}, waddr}; // zero extend
		return wide_addr ^ INIT_KEY;
	endfunction

endpackage
